// ==== div_pkg.sv ====
/*
 * shared types for the iterative 32-bit divider
 * operand width is fixed here and the iteration count follows from it
 */

package div_pkg;

  // ------------------------------------------------------------
  // widths
  // ------------------------------------------------------------

  // operand, quotient and remainder width
  localparam int word_bits = 32;

  // remainder half plus quotient half plus one borrow bit
  localparam int acc_bits = 2 * word_bits + 1;

  // one iteration per quotient bit
  localparam int div_iters = word_bits;

  // counter runs from div_iters-1 down to zero
  localparam int count_bits = $clog2(div_iters);

  // ------------------------------------------------------------
  // plain vector types
  // ------------------------------------------------------------

  typedef logic [word_bits-1:0]  word_t;
  typedef logic [acc_bits-1:0]   acc_t;
  typedef logic [count_bits-1:0] count_t;

  // ------------------------------------------------------------
  // enums
  // ------------------------------------------------------------

  // function bit of a request
  typedef enum logic {
    div_unsigned = 1'b0,
    div_signed   = 1'b1
  } div_fn_e;

  // control FSM states
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_done = 2'd2
  } ctrl_state_e;

  // ------------------------------------------------------------
  // messages
  // ------------------------------------------------------------

  // request, fn on top, 65 bits
  typedef struct packed {
    div_fn_e fn;
    word_t   a;
    word_t   b;
  } div_req_t;

  // response, remainder in the upper word, 64 bits
  typedef struct packed {
    word_t remainder;
    word_t quotient;
  } div_resp_t;

endpackage

// ==== int_div_dpath.sv ====
/*
 * restoring divider datapath, 32 shift/subtract steps per request
 * divisor of zero gives an unspecified result
 */

`timescale 1ns/100ps

module int_div_dpath (
  input  logic              clk,
  input  logic              reset,

  // operands, sampled on the load edge only
  input  div_pkg::word_t    a,
  input  div_pkg::word_t    b,

  // strobes from the control unit
  input  logic              a_en,
  input  logic              b_en,
  input  logic              a_mux_sel,
  input  logic              sub_mux_sel,
  input  logic              cntr_mux_sel,
  input  logic              sign_en,
  input  logic              is_signed,
  input  logic              div_sign_mux_sel,
  input  logic              rem_sign_mux_sel,

  output div_pkg::div_resp_t resp,

  // status back to the control unit
  output logic              sub_neg,
  output logic              counter_is_zero,
  output logic              div_sign,
  output logic              rem_sign
);

  // ------------------------------------------------------------
  // registers
  // ------------------------------------------------------------

  // remainder in [63:32], quotient bits shift in at [31:0]
  div_pkg::acc_t   acc_reg;
  // divisor sits at [63:32] so it lines up with the remainder half
  div_pkg::acc_t   div_reg;
  div_pkg::count_t counter_reg;
  logic            div_sign_reg;
  logic            rem_sign_reg;

  // ------------------------------------------------------------
  // operand load
  // ------------------------------------------------------------

  div_pkg::word_t a_mag;
  div_pkg::word_t b_mag;
  div_pkg::word_t a_norm;
  div_pkg::word_t b_norm;
  div_pkg::acc_t  acc_init;
  div_pkg::acc_t  div_init;

  // two's complement magnitude of each operand
  assign a_mag = a[div_pkg::word_bits-1] ? div_pkg::word_t'(~a + 1'b1) : a;
  assign b_mag = b[div_pkg::word_bits-1] ? div_pkg::word_t'(~b + 1'b1) : b;

  // unsigned requests pass straight through
  assign a_norm = is_signed ? a_mag : a;
  assign b_norm = is_signed ? b_mag : b;

  // dividend in the low half, upper half and borrow bit cleared
  assign acc_init = {{(div_pkg::word_bits + 1){1'b0}}, a_norm};
  // divisor shifted up by one word
  assign div_init = {1'b0, b_norm, {div_pkg::word_bits{1'b0}}};

  // ------------------------------------------------------------
  // shift, subtract, restore
  // ------------------------------------------------------------

  div_pkg::acc_t acc_shift;
  div_pkg::acc_t acc_diff;
  div_pkg::acc_t acc_keep;
  div_pkg::acc_t acc_restore;
  div_pkg::acc_t acc_step;
  div_pkg::acc_t acc_next;

  assign acc_shift = {acc_reg[div_pkg::acc_bits-2:0], 1'b0};
  assign acc_diff  = acc_shift - div_reg;

  // top bit set means the trial subtraction borrowed
  assign sub_neg = acc_diff[div_pkg::acc_bits-1];

  // subtraction fits, keep it and shift in a one
  assign acc_keep    = {acc_diff[div_pkg::acc_bits-1:1], 1'b1};
  // subtraction borrowed, go back to the shifted value with a zero
  assign acc_restore = {acc_shift[div_pkg::acc_bits-1:1], 1'b0};

  assign acc_step = sub_mux_sel ? acc_restore : acc_keep;
  assign acc_next = a_mux_sel ? acc_step : acc_init;

  always_ff @(posedge clk) begin
    if (a_en) begin
      acc_reg <= acc_next;
    end
    if (b_en) begin
      div_reg <= div_init;
    end
  end

  // ------------------------------------------------------------
  // iteration counter
  // ------------------------------------------------------------

  div_pkg::count_t counter_next;

  // reload with the last index outside calc, count down inside it
  assign counter_next = cntr_mux_sel ? div_pkg::count_t'(counter_reg - 1'b1)
                                     : div_pkg::count_t'(div_pkg::div_iters - 1);

  always_ff @(posedge clk) begin
    if (reset) begin
      counter_reg <= '0;
    end else begin
      counter_reg <= counter_next;
    end
  end

  assign counter_is_zero = (counter_reg == '0);

  // ------------------------------------------------------------
  // sign flags
  // ------------------------------------------------------------

  // raw sign bits, the control unit only uses them for signed requests
  always_ff @(posedge clk) begin
    if (sign_en) begin
      div_sign_reg <= a[div_pkg::word_bits-1] ^ b[div_pkg::word_bits-1];
      rem_sign_reg <= a[div_pkg::word_bits-1];
    end
  end

  assign div_sign = div_sign_reg;
  assign rem_sign = rem_sign_reg;

  // ------------------------------------------------------------
  // result sign correction
  // ------------------------------------------------------------

  div_pkg::word_t quo_raw;
  div_pkg::word_t rem_raw;

  assign quo_raw = acc_reg[div_pkg::word_bits-1:0];
  assign rem_raw = acc_reg[2*div_pkg::word_bits-1:div_pkg::word_bits];

  // negation wraps, so the most negative quotient stays as it is
  always_comb begin
    resp.quotient  = div_sign_mux_sel ? div_pkg::word_t'(~quo_raw + 1'b1) : quo_raw;
    resp.remainder = rem_sign_mux_sel ? div_pkg::word_t'(~rem_raw + 1'b1) : rem_raw;
  end

endmodule

// ==== int_div_ctrl.sv ====
/*
 * divider control FSM, one request in flight
 * outputs are combinational from state, handshake inputs and sub_neg
 */

`timescale 1ns/100ps

module int_div_ctrl (
  input  logic             clk,
  input  logic             reset,

  // function bit of the pending request
  input  div_pkg::div_fn_e fn,

  // handshake with the outside
  input  logic             req_val,
  input  logic             resp_rdy,
  output logic             req_rdy,
  output logic             resp_val,

  // status from the datapath
  input  logic             sub_neg,
  input  logic             counter_is_zero,
  input  logic             div_sign,
  input  logic             rem_sign,

  // datapath control
  output logic             is_signed,
  output logic             a_en,
  output logic             b_en,
  output logic             a_mux_sel,
  output logic             sub_mux_sel,
  output logic             cntr_mux_sel,
  output logic             sign_en,
  output logic             div_sign_mux_sel,
  output logic             rem_sign_mux_sel
);

  // ------------------------------------------------------------
  // state and captured function
  // ------------------------------------------------------------

  div_pkg::ctrl_state_e state;
  div_pkg::ctrl_state_e state_next;
  div_pkg::div_fn_e     fn_reg;

  logic req_go;
  logic resp_go;

  // transfer on either side needs both valid and ready
  assign req_go  = (state == div_pkg::st_idle) && req_val;
  assign resp_go = (state == div_pkg::st_done) && resp_rdy;

  always_comb begin
    state_next = state;
    case (state)
      div_pkg::st_idle: begin
        if (req_go) begin
          state_next = div_pkg::st_calc;
        end
      end
      // last step happens on the edge that leaves calc
      div_pkg::st_calc: begin
        if (counter_is_zero) begin
          state_next = div_pkg::st_done;
        end
      end
      // hold the result until the consumer takes it
      div_pkg::st_done: begin
        if (resp_go) begin
          state_next = div_pkg::st_idle;
        end
      end
      default: begin
        state_next = div_pkg::st_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= div_pkg::st_idle;
      fn_reg <= div_pkg::div_unsigned;
    end else begin
      state <= state_next;
      // later changes on fn are ignored until the next accept
      if (req_go) begin
        fn_reg <= fn;
      end
    end
  end

  // ------------------------------------------------------------
  // control outputs
  // ------------------------------------------------------------

  always_comb begin
    req_rdy          = 1'b0;
    resp_val         = 1'b0;
    is_signed        = (fn_reg == div_pkg::div_signed);
    a_en             = 1'b0;
    b_en             = 1'b0;
    a_mux_sel        = 1'b0;
    sub_mux_sel      = 1'b0;
    cntr_mux_sel     = 1'b0;
    sign_en          = 1'b0;
    div_sign_mux_sel = 1'b0;
    rem_sign_mux_sel = 1'b0;

    case (state)
      div_pkg::st_idle: begin
        req_rdy   = 1'b1;
        // live fn picks the magnitude conversion on the load edge
        is_signed = (fn == div_pkg::div_signed);
        // load operands and signs, counter reloads with 31
        a_en      = req_go;
        b_en      = req_go;
        sign_en   = req_go;
      end
      div_pkg::st_calc: begin
        // one shift per cycle, restore when the subtraction borrows
        a_en         = 1'b1;
        a_mux_sel    = 1'b1;
        sub_mux_sel  = sub_neg;
        cntr_mux_sel = 1'b1;
      end
      div_pkg::st_done: begin
        resp_val         = 1'b1;
        // negate only for signed requests
        div_sign_mux_sel = is_signed && div_sign;
        rem_sign_mux_sel = is_signed && rem_sign;
      end
      default: begin
        req_rdy = 1'b0;
      end
    endcase
  end

endmodule

// ==== int_div_iterative.sv ====
/*
 * iterative 32-bit integer divider, valid/ready on both sides
 * response 32 cycles after accept, divide by zero is unspecified
 */

`timescale 1ns/100ps

module int_div_iterative (
  input  logic               clk,
  input  logic               reset,

  // request side
  input  div_pkg::div_req_t  req,
  input  logic               req_val,
  output logic               req_rdy,

  // response side
  output div_pkg::div_resp_t resp,
  output logic               resp_val,
  input  logic               resp_rdy
);

  // ------------------------------------------------------------
  // control to datapath
  // ------------------------------------------------------------

  logic a_en;
  logic b_en;
  logic a_mux_sel;
  logic sub_mux_sel;
  logic cntr_mux_sel;
  logic sign_en;
  logic is_signed;
  logic div_sign_mux_sel;
  logic rem_sign_mux_sel;

  // datapath status back to control
  logic sub_neg;
  logic counter_is_zero;
  logic div_sign;
  logic rem_sign;

  // FSM sees only the function bit
  int_div_ctrl ctrl (
    .clk              (clk),
    .reset            (reset),
    .fn               (req.fn),
    .req_val          (req_val),
    .resp_rdy         (resp_rdy),
    .req_rdy          (req_rdy),
    .resp_val         (resp_val),
    .sub_neg          (sub_neg),
    .counter_is_zero  (counter_is_zero),
    .div_sign         (div_sign),
    .rem_sign         (rem_sign),
    .is_signed        (is_signed),
    .a_en             (a_en),
    .b_en             (b_en),
    .a_mux_sel        (a_mux_sel),
    .sub_mux_sel      (sub_mux_sel),
    .cntr_mux_sel     (cntr_mux_sel),
    .sign_en          (sign_en),
    .div_sign_mux_sel (div_sign_mux_sel),
    .rem_sign_mux_sel (rem_sign_mux_sel)
  );

  // operands go to the datapath, which drives resp itself
  int_div_dpath dpath (
    .clk              (clk),
    .reset            (reset),
    .a                (req.a),
    .b                (req.b),
    .a_en             (a_en),
    .b_en             (b_en),
    .a_mux_sel        (a_mux_sel),
    .sub_mux_sel      (sub_mux_sel),
    .cntr_mux_sel     (cntr_mux_sel),
    .sign_en          (sign_en),
    .is_signed        (is_signed),
    .div_sign_mux_sel (div_sign_mux_sel),
    .rem_sign_mux_sel (rem_sign_mux_sel),
    .resp             (resp),
    .sub_neg          (sub_neg),
    .counter_is_zero  (counter_is_zero),
    .div_sign         (div_sign),
    .rem_sign         (rem_sign)
  );

endmodule

// ==== int_div_iterative_sva.sv ====
/*
 * handshake and latency checks for the divider top level
 * latency assumes 32 calc cycles between accept and done
 */

`timescale 1ns/100ps

module int_div_iterative_sva (
  input logic                 clk,
  input logic                 reset,
  input logic                 req_val,
  input logic                 req_rdy,
  input div_pkg::div_resp_t   resp,
  input logic                 resp_val,
  input logic                 resp_rdy,
  input div_pkg::ctrl_state_e state
);

  // number of failed assertions, summed into the testbench error count
  int fail_count = 0;

  logic req_fire;
  logic resp_fire;
  logic busy;

  assign req_fire  = req_val && req_rdy;
  assign resp_fire = resp_val && resp_rdy;

  // one request in flight, set by the accept and cleared by the response transfer
  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
    end else if (req_fire) begin
      busy <= 1'b1;
    end else if (resp_fire) begin
      busy <= 1'b0;
    end
  end

  // idle with nothing pending once reset has been seen
  reset_idle: assert property (@(posedge clk) reset |=> (req_rdy && !resp_val))
    else begin $error("req_rdy/resp_val wrong after reset"); fail_count++; end

  // no accept between an accept and its response transfer
  busy_no_rdy: assert property (@(posedge clk) disable iff (reset) busy |-> !req_rdy)
    else begin $error("req_rdy high while a request is in flight"); fail_count++; end

  // resp_val comes up 32 cycles after the accepting edge
  lat_fwd: assert property (@(posedge clk) disable iff (reset) req_fire |-> ##33 resp_val)
    else begin $error("resp_val late after accept"); fail_count++; end
  lat_back: assert property (@(posedge clk) disable iff (reset)
    $rose(resp_val) |-> $past(req_fire, 33))
    else begin $error("resp_val early after accept"); fail_count++; end

  // back-pressure holds the result
  hold_resp: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp)))
    else begin $error("resp changed under back-pressure"); fail_count++; end

  // transfer edge goes back to idle
  back_idle: assert property (@(posedge clk) disable iff (reset)
    resp_fire |=> ((state == div_pkg::st_idle) && req_rdy && !resp_val))
    else begin $error("not idle after response transfer"); fail_count++; end

endmodule

bind int_div_iterative int_div_iterative_sva sva (
  .clk      (clk),
  .reset    (reset),
  .req_val  (req_val),
  .req_rdy  (req_rdy),
  .resp     (resp),
  .resp_val (resp_val),
  .resp_rdy (resp_rdy),
  .state    (ctrl.state)
);

// ==== tb_int_div_iterative.sv ====
/*
 * testbench for the iterative divider, never divides by zero
 * results are checked here, handshake timing by the bound SVA module
 */

`timescale 1ns/100ps

module tb_int_div_iterative;

  // ------------------------------------------------------------
  // run length and watchdog limit
  // ------------------------------------------------------------

  localparam int num_directed = 18;
  localparam int num_random   = 300;
  localparam int max_stall    = 7;
  // 40 cycles per request, worst case stalls, reset and slack
  localparam int timeout_cycles = (num_directed + num_random) * (40 + max_stall) + 200;

  logic               clk;
  logic               reset;
  div_pkg::div_req_t  req;
  logic               req_val;
  logic               req_rdy;
  div_pkg::div_resp_t resp;
  logic               resp_val;
  logic               resp_rdy;

  int error_count;
  int check_count;
  int cycle_count = 0;

  int_div_iterative dut (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp     (resp),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > timeout_cycles) begin
      $display("timeout: no response after %0d cycles", cycle_count);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // reference model, 64-bit math so min / -1 needs no special case
  // ------------------------------------------------------------

  function automatic div_pkg::div_resp_t model_div(input div_pkg::div_fn_e fn,
                                                   input div_pkg::word_t a,
                                                   input div_pkg::word_t b);
    longint num;
    longint den;
    longint quo;
    longint rem;
    div_pkg::div_resp_t res;
    if (fn == div_pkg::div_signed) begin
      num = longint'($signed(a));
      den = longint'($signed(b));
    end else begin
      num = longint'({32'h0, a});
      den = longint'({32'h0, b});
    end
    // truncates toward zero, remainder follows the dividend
    quo = num / den;
    rem = num - quo * den;
    res.quotient  = quo[31:0];
    res.remainder = rem[31:0];
    return res;
  endfunction

  // junk on the request port while the unit is busy
  task automatic disturb_req();
    req.fn  = ($urandom_range(0, 1) != 0) ? div_pkg::div_signed : div_pkg::div_unsigned;
    req.a   = $urandom();
    req.b   = $urandom();
    req_val = ($urandom_range(0, 1) != 0);
  endtask

  // one request, optional back-pressure, compare at the transfer
  task automatic run_div(input div_pkg::div_fn_e fn, input div_pkg::word_t a,
                         input div_pkg::word_t b, input bit scramble);
    div_pkg::div_resp_t expected;
    int stall;
    expected = model_div(fn, a, b);
    stall = ($urandom_range(0, 1) != 0) ? int'($urandom_range(1, max_stall)) : 0;
    @(posedge clk);
    #2;
    req.fn  = fn;
    req.a   = a;
    req.b   = b;
    req_val = 1'b1;
    while (!req_rdy) begin
      @(posedge clk);
      #2;
    end
    // ready is up, so the next edge takes the request
    @(posedge clk);
    #2;
    req_val = 1'b0;
    while (!resp_val) begin
      if (scramble) disturb_req();
      @(posedge clk);
      #2;
    end
    repeat (stall) begin
      if (scramble) disturb_req();
      @(posedge clk);
      #2;
    end
    resp_rdy = 1'b1;
    check_count++;
    quo_ok: assert (resp.quotient === expected.quotient) else begin
      $display("** Error: resp.quotient = %h, expected %h (fn %0d, a %h, b %h)",
               resp.quotient, expected.quotient, fn, a, b);
      error_count++;
    end
    rem_ok: assert (resp.remainder === expected.remainder) else begin
      $display("** Error: resp.remainder = %h, expected %h (fn %0d, a %h, b %h)",
               resp.remainder, expected.remainder, fn, a, b);
      error_count++;
    end
    @(posedge clk);
    #2;
    resp_rdy = 1'b0;
    req_val  = 1'b0;
  endtask

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------

  initial begin
    div_pkg::word_t rand_a;
    div_pkg::word_t rand_b;
    div_pkg::div_fn_e rand_fn;
    void'($urandom(89));
    req         = '0;
    req_val     = 1'b0;
    resp_rdy    = 1'b0;
    reset       = 1'b1;
    error_count = 0;
    check_count = 0;
    repeat (4) @(posedge clk);
    #2;
    reset = 1'b0;

    // unsigned corners
    run_div(div_pkg::div_unsigned, 32'd5, 32'd7, 1'b0);
    run_div(div_pkg::div_unsigned, 32'd123, 32'd123, 1'b0);
    run_div(div_pkg::div_unsigned, 32'hDEADBEEF, 32'd1, 1'b0);
    run_div(div_pkg::div_unsigned, 32'hFFFFFFFF, 32'd1, 1'b0);
    run_div(div_pkg::div_unsigned, 32'hFFFFFFFF, 32'd10, 1'b0);
    run_div(div_pkg::div_unsigned, 32'hFFFFFFFF, 32'hFFFFFFFF, 1'b0);
    run_div(div_pkg::div_unsigned, 32'd0, 32'd9, 1'b0);
    run_div(div_pkg::div_unsigned, 32'h80000000, 32'hFFFFFFFF, 1'b0);

    // signed, all four sign pairs of 7 and 2
    run_div(div_pkg::div_signed, 32'd7, 32'd2, 1'b0);
    run_div(div_pkg::div_signed, 32'hFFFFFFF9, 32'd2, 1'b0);
    run_div(div_pkg::div_signed, 32'd7, 32'hFFFFFFFE, 1'b0);
    run_div(div_pkg::div_signed, 32'hFFFFFFF9, 32'hFFFFFFFE, 1'b0);
    // most negative over minus one wraps back to itself
    run_div(div_pkg::div_signed, 32'h80000000, 32'hFFFFFFFF, 1'b0);
    run_div(div_pkg::div_signed, 32'h80000000, 32'd2, 1'b0);
    run_div(div_pkg::div_signed, 32'h7FFFFFFF, 32'h80000000, 1'b0);

    // request port keeps changing during calc and done
    run_div(div_pkg::div_signed, 32'hFFFFFF9C, 32'd7, 1'b1);
    run_div(div_pkg::div_unsigned, 32'hFFFFFF9C, 32'd7, 1'b1);
    run_div(div_pkg::div_signed, 32'h12345678, 32'hFFFFF000, 1'b1);

    // 200 unsigned then 100 signed, divisor widths spread by a shift
    for (int i = 0; i < num_random; i++) begin
      rand_fn = (i < 200) ? div_pkg::div_unsigned : div_pkg::div_signed;
      rand_a  = $urandom();
      do begin
        rand_b = $urandom() >> $urandom_range(0, 31);
      end while (rand_b == 32'd0);
      run_div(rand_fn, rand_a, rand_b, (i % 5) == 0);
    end

    repeat (2) @(posedge clk);
    error_count += dut.sva.fail_count;
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
div_pkg.sv
int_div_dpath.sv
int_div_ctrl.sv
int_div_iterative.sv
int_div_iterative_sva.sv
tb_int_div_iterative.sv

// ==== run_verilator.sh ====
#!/bin/sh
# build and run the divider testbench with Verilator
cd "$(dirname "$0")" || exit 1
log=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -f vlog.f --top-module tb_int_div_iterative -o sim_div
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

# keep running past assertion errors so the testbench prints its summary
./obj_dir/sim_div +verilator+error+limit+1000 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TESTBENCH PASSED$" "$log"; then
  exit 0
fi
exit 1
